// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --timing --assert
TOP := tb_backend
FILELIST := files.f
BUILD_DIR := obj_dir
PASS_MSG := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
hw/pipeline_pkg.sv
hw/dispatch_regfile_if.sv
hw/regfile.sv
hw/decoder.sv
hw/dispatch.sv
hw/execute.sv
hw/mem_wb.sv
hw/backend.sv
sim/clk_gen.sv
sim/tb_backend.sv

// ==== hw/backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend (
    input logic clk,
    input logic rst_i,

    // frontend
    input logic inst_valid_i,
    input logic [31:0] inst_i,
    input logic [31:0] pc_i,
    output logic stall_o,

    // data memory
    output logic dmem_en_o,
    output logic dmem_we_o,
    output logic [31:0] dmem_addr_o,
    output logic [31:0] dmem_wdata_o,
    input logic [31:0] dmem_rdata_i,

    // writeback trace
    output logic [31:0] debug_wb_pc_o,
    output logic debug_wb_rf_we_o,
    output logic [4:0] debug_wb_rf_wnum_o,
    output logic [31:0] debug_wb_rf_wdata_o
);
    import pipeline_pkg::*;

    dispatch_regfile_if rf_io ();

    id_dispatch_t id_rec;
    dispatch_ex_t ex_rec;
    ex_mem_t mem_rec;
    push_forward_t ex_fwd;
    push_forward_t mem_fwd;
    logic ex_is_load;

    decoder u_decoder (
        .clk,
        .rst_i,
        .inst_valid_i,
        .inst_i,
        .pc_i,
        .stall_i(stall_o),
        .id_o(id_rec)
    );

    dispatch u_dispatch (
        .clk,
        .rst_i,
        .id_i(id_rec),
        .rf(rf_io.master),
        .ex_forward_i(ex_fwd),
        .mem_forward_i(mem_fwd),
        .ex_is_load_i(ex_is_load),
        .stall_o,
        .dispatch_o(ex_rec)
    );

    execute u_execute (
        .clk,
        .rst_i,
        .ex_i(ex_rec),
        .ex_forward_o(ex_fwd),
        .ex_is_load_o(ex_is_load),
        .dmem_en_o,
        .dmem_we_o,
        .dmem_addr_o,
        .dmem_wdata_o,
        .mem_o(mem_rec)
    );

    mem_wb u_mem_wb (
        .clk,
        .rst_i,
        .mem_i(mem_rec),
        .dmem_rdata_i,
        .mem_forward_o(mem_fwd),
        .wb_we_o(debug_wb_rf_we_o),
        .wb_waddr_o(debug_wb_rf_wnum_o),
        .wb_wdata_o(debug_wb_rf_wdata_o),
        .wb_pc_o(debug_wb_pc_o)
    );

    // writeback record is also the debug trace
    regfile u_regfile (
        .clk,
        .rst_i,
        .we_i(debug_wb_rf_we_o),
        .waddr_i(debug_wb_rf_wnum_o),
        .wdata_i(debug_wb_rf_wdata_o),
        .rf(rf_io.slave)
    );

endmodule

`default_nettype wire

// ==== hw/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input logic clk,
    input logic rst_i,

    input logic inst_valid_i,
    input pipeline_pkg::inst_t inst_i,
    input logic [31:0] pc_i,
    input logic stall_i,

    output pipeline_pkg::id_dispatch_t id_o
);
    import pipeline_pkg::*;

    id_dispatch_t dec;
    logic known;
    logic writes_rd;

    always_comb begin
        dec = '0;
        dec.pc = pc_i;
        dec.aluop = op_none;
        known = 1'b1;
        writes_rd = 1'b1;

        if (inst_i.r3.opcode == opc_add_w || inst_i.r3.opcode == opc_sub_w ||
            inst_i.r3.opcode == opc_and || inst_i.r3.opcode == opc_or ||
            inst_i.r3.opcode == opc_xor) begin
            dec.rj = inst_i.r3.rj;
            dec.rk_or_rd_src = inst_i.r3.rk;
            dec.reg_write_addr = inst_i.r3.rd;
            case (inst_i.r3.opcode)
                opc_add_w: dec.aluop = op_add;
                opc_sub_w: dec.aluop = op_sub;
                opc_and: dec.aluop = op_and;
                opc_or: dec.aluop = op_or;
                default: dec.aluop = op_xor;
            endcase
        end else if (inst_i.ri12.opcode == opc_addi_w || inst_i.ri12.opcode == opc_ld_w ||
                     inst_i.ri12.opcode == opc_st_w) begin
            dec.rj = inst_i.ri12.rj;
            dec.reg_write_addr = inst_i.ri12.rd;
            dec.imm = {{(xlen - 12){inst_i.ri12.imm12[11]}}, inst_i.ri12.imm12};
            dec.use_imm = 1'b1;
            if (inst_i.ri12.opcode == opc_addi_w) begin
                dec.aluop = op_add;
            end else if (inst_i.ri12.opcode == opc_ld_w) begin
                dec.aluop = op_load;
            end else begin
                // store data comes from rd
                dec.aluop = op_store;
                dec.rk_or_rd_src = inst_i.ri12.rd;
                writes_rd = 1'b0;
            end
        end else if (inst_i.ri20.opcode == opc_lu12i_w) begin
            dec.aluop = op_lui;
            dec.reg_write_addr = inst_i.ri20.rd;
            dec.imm = {inst_i.ri20.imm20, 12'b0};
            dec.use_imm = 1'b1;
        end else begin
            known = 1'b0;
        end

        dec.valid = inst_valid_i && known && inst_i != nop_word;
        dec.reg_write_en = dec.valid && writes_rd && dec.reg_write_addr != '0;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_o <= '0;
        end else if (!stall_i) begin
            id_o <= dec;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch (
    input logic clk,
    input logic rst_i,

    input pipeline_pkg::id_dispatch_t id_i,

    dispatch_regfile_if.master rf,

    input pipeline_pkg::push_forward_t ex_forward_i,
    input pipeline_pkg::push_forward_t mem_forward_i,
    input logic ex_is_load_i,

    output logic stall_o,
    output pipeline_pkg::dispatch_ex_t dispatch_o
);
    import pipeline_pkg::*;

    logic [xlen-1:0] rj_val;
    logic [xlen-1:0] r2_val;
    logic load_stall;
    dispatch_ex_t nxt;

    // ex wins over mem, mem over the regfile read
    function automatic logic [xlen-1:0] resolve(
        input logic [reg_addr_w-1:0] addr,
        input logic [xlen-1:0] rf_data,
        input push_forward_t ex_fwd,
        input push_forward_t mem_fwd
    );
        logic [xlen-1:0] data;
        data = rf_data;
        if (mem_fwd.reg_write_en && mem_fwd.reg_write_addr == addr) begin
            data = mem_fwd.reg_write_data;
        end
        if (ex_fwd.reg_write_en && ex_fwd.reg_write_addr == addr) begin
            data = ex_fwd.reg_write_data;
        end
        return data;
    endfunction

    assign rf.raddr1 = id_i.rj;
    assign rf.raddr2 = id_i.rk_or_rd_src;

    assign rj_val = resolve(id_i.rj, rf.rdata1, ex_forward_i, mem_forward_i);
    assign r2_val = resolve(id_i.rk_or_rd_src, rf.rdata2, ex_forward_i, mem_forward_i);

    // load data is not ready until mem, unused sources are r0
    assign load_stall = id_i.valid && ex_is_load_i &&
                        (id_i.rj == ex_forward_i.reg_write_addr ||
                         id_i.rk_or_rd_src == ex_forward_i.reg_write_addr);

    assign stall_o = load_stall;

    always_comb begin
        nxt.valid = id_i.valid && !load_stall;
        nxt.pc = id_i.pc;
        nxt.aluop = id_i.aluop;
        nxt.src1 = rj_val;
        nxt.src2 = id_i.use_imm ? id_i.imm : r2_val;
        nxt.store_data = r2_val;
        nxt.reg_write_en = id_i.reg_write_en && !load_stall;
        nxt.reg_write_addr = id_i.reg_write_addr;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dispatch_o <= '0;
        end else begin
            dispatch_o <= nxt;
        end
    end

    // the bubble put into execute clears the hazard
    assert property (@(posedge clk) disable iff (rst_i) stall_o |=> !stall_o);

endmodule

`default_nettype wire

// ==== hw/dispatch_regfile_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dispatch_regfile_if;
    import pipeline_pkg::*;

    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;

    modport master (
        output raddr1, raddr2,
        input rdata1, rdata2
    );

    modport slave (
        input raddr1, raddr2,
        output rdata1, rdata2
    );

endinterface

`default_nettype wire

// ==== hw/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute (
    input logic clk,
    input logic rst_i,

    input pipeline_pkg::dispatch_ex_t ex_i,

    output pipeline_pkg::push_forward_t ex_forward_o,
    output logic ex_is_load_o,

    output logic dmem_en_o,
    output logic dmem_we_o,
    output logic [pipeline_pkg::xlen-1:0] dmem_addr_o,
    output logic [pipeline_pkg::xlen-1:0] dmem_wdata_o,

    output pipeline_pkg::ex_mem_t mem_o
);
    import pipeline_pkg::*;

    logic [xlen-1:0] alu_res;
    logic is_load;
    logic is_store;

    always_comb begin
        case (ex_i.aluop)
            op_add, op_load, op_store: alu_res = ex_i.src1 + ex_i.src2;
            op_sub: alu_res = ex_i.src1 - ex_i.src2;
            op_and: alu_res = ex_i.src1 & ex_i.src2;
            op_or: alu_res = ex_i.src1 | ex_i.src2;
            op_xor: alu_res = ex_i.src1 ^ ex_i.src2;
            op_lui: alu_res = ex_i.src2;
            default: alu_res = '0;
        endcase
    end

    assign is_load = ex_i.aluop == op_load;
    assign is_store = ex_i.aluop == op_store;

    // request is sampled by the memory at the next edge
    assign dmem_en_o = ex_i.valid && (is_load || is_store);
    assign dmem_we_o = ex_i.valid && is_store;
    assign dmem_addr_o = alu_res;
    assign dmem_wdata_o = ex_i.store_data;

    // address still drives the hazard check for loads
    assign ex_forward_o.reg_write_en = ex_i.valid && ex_i.reg_write_en && !is_load;
    assign ex_forward_o.reg_write_addr = ex_i.reg_write_addr;
    assign ex_forward_o.reg_write_data = alu_res;

    assign ex_is_load_o = ex_i.valid && is_load && ex_i.reg_write_en;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_o <= '0;
        end else begin
            mem_o.valid <= ex_i.valid;
            mem_o.pc <= ex_i.pc;
            mem_o.is_load <= is_load;
            mem_o.reg_write_en <= ex_i.valid && ex_i.reg_write_en;
            mem_o.reg_write_addr <= ex_i.reg_write_addr;
            mem_o.result <= alu_res;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wb (
    input logic clk,
    input logic rst_i,

    input pipeline_pkg::ex_mem_t mem_i,
    input logic [31:0] dmem_rdata_i,

    output pipeline_pkg::push_forward_t mem_forward_o,

    output logic wb_we_o,
    output logic [pipeline_pkg::reg_addr_w-1:0] wb_waddr_o,
    output logic [pipeline_pkg::xlen-1:0] wb_wdata_o,
    output logic [31:0] wb_pc_o
);
    import pipeline_pkg::*;

    logic [xlen-1:0] sel_data;
    logic write_en;

    // read data arrives in the cycle after the request
    assign sel_data = mem_i.is_load ? dmem_rdata_i : mem_i.result;
    assign write_en = mem_i.valid && mem_i.reg_write_en;

    assign mem_forward_o.reg_write_en = write_en;
    assign mem_forward_o.reg_write_addr = mem_i.reg_write_addr;
    assign mem_forward_o.reg_write_data = sel_data;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_we_o <= 1'b0;
            wb_waddr_o <= '0;
            wb_wdata_o <= '0;
            wb_pc_o <= '0;
        end else begin
            wb_we_o <= write_en;
            wb_waddr_o <= mem_i.reg_write_addr;
            wb_wdata_o <= sel_data;
            wb_pc_o <= mem_i.pc;
        end
    end

endmodule

`default_nettype wire

// ==== hw/pipeline_pkg.sv ====
`default_nettype none

package pipeline_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_num = 1 << reg_addr_w;

    // andi r0, r0, 0
    localparam logic [31:0] nop_word = 32'h0340_0000;

    // major opcodes, one per instruction layout
    localparam logic [16:0] opc_add_w = 17'h00020;
    localparam logic [16:0] opc_sub_w = 17'h00022;
    localparam logic [16:0] opc_and = 17'h00029;
    localparam logic [16:0] opc_or = 17'h0002a;
    localparam logic [16:0] opc_xor = 17'h0002b;
    localparam logic [9:0] opc_addi_w = 10'h00a;
    localparam logic [9:0] opc_ld_w = 10'h0a2;
    localparam logic [9:0] opc_st_w = 10'h0a6;
    localparam logic [6:0] opc_lu12i_w = 7'h0a;

    typedef enum logic [3:0] {
        op_none,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_lui,
        op_load,
        op_store
    } aluop_t;

    typedef struct packed {
        logic [16:0] opcode;
        logic [reg_addr_w-1:0] rk;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rd;
    } inst_r3_t;

    typedef struct packed {
        logic [9:0] opcode;
        logic [11:0] imm12;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rd;
    } inst_ri12_t;

    typedef struct packed {
        logic [6:0] opcode;
        logic [19:0] imm20;
        logic [reg_addr_w-1:0] rd;
    } inst_ri20_t;

    typedef union packed {
        inst_r3_t r3;
        inst_ri12_t ri12;
        inst_ri20_t ri20;
    } inst_t;

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        aluop_t aluop;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rk_or_rd_src;
        logic [xlen-1:0] imm;
        logic use_imm;
        logic reg_write_en;
        logic [reg_addr_w-1:0] reg_write_addr;
    } id_dispatch_t;

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        aluop_t aluop;
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
        logic [xlen-1:0] store_data;
        logic reg_write_en;
        logic [reg_addr_w-1:0] reg_write_addr;
    } dispatch_ex_t;

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        logic is_load;
        logic reg_write_en;
        logic [reg_addr_w-1:0] reg_write_addr;
        logic [xlen-1:0] result;
    } ex_mem_t;

    typedef struct packed {
        logic reg_write_en;
        logic [reg_addr_w-1:0] reg_write_addr;
        logic [xlen-1:0] reg_write_data;
    } push_forward_t;

endpackage

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input logic clk,
    input logic rst_i,

    input logic we_i,
    input logic [pipeline_pkg::reg_addr_w-1:0] waddr_i,
    input logic [pipeline_pkg::xlen-1:0] wdata_i,

    dispatch_regfile_if.slave rf
);
    import pipeline_pkg::*;

    logic [xlen-1:0] regs [reg_num];

    // same-cycle write is visible to the reader
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
        logic [xlen-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (we_i && waddr_i == addr) begin
            data = wdata_i;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < reg_num; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rf.rdata1 = read_port(rf.raddr1);
        rf.rdata2 = read_port(rf.raddr2);
    end

    // decoder drops r0 destinations, so none should reach writeback
    assert property (@(posedge clk) disable iff (rst_i) !(we_i && waddr_i == '0));

endmodule

`default_nettype wire

// ==== sim/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset spans the first five rising edges
    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        rst_o <= 1'b0;
    end
endmodule

`default_nettype wire

// ==== sim/tb_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_backend;
    // andi r0, r0, 0
    localparam logic [31:0] nop_word = 32'h0340_0000;
    localparam int idle_cycles = 10;
    localparam int alu_count = 64;
    localparam int mem_pairs = 12;
    localparam int use_pairs = 10;
    localparam int gap_count = 64;
    localparam int junk_count = 48;
    localparam int slot_total = idle_cycles + alu_count + 7 + 2 * mem_pairs +
                                3 * use_pairs + gap_count + junk_count;

    logic clk;
    logic rst;
    logic inst_valid_i = 1'b0;
    logic [31:0] inst_i = '0;
    logic [31:0] pc_i = '0;
    logic stall_o;
    logic dmem_en_o;
    logic dmem_we_o;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;
    logic [31:0] dmem_rdata_i = '0;
    logic [31:0] debug_wb_pc_o;
    logic debug_wb_rf_we_o;
    logic [4:0] debug_wb_rf_wnum_o;
    logic [31:0] debug_wb_rf_wdata_o;

    logic [31:0] lfsr = 32'hbfb7;
    logic [31:0] sregs [32];
    logic [31:0] smem [256];
    logic [31:0] dmem [256];
    logic [31:0] read_hold = '0;
    logic [31:0] pc_next = 32'h1c00_0000;
    logic [31:0] exp_wnum [$];
    logic [31:0] exp_wdata [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_saddr [$];
    logic [31:0] exp_sdata [$];
    string test_name = "reset";
    int errors = 0;
    int checks = 0;
    int err_mark = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int stall_cycles = 0;

    clk_gen u_clk_gen (
        .clk_o(clk),
        .rst_o(rst)
    );

    backend dut (
        .clk,
        .rst_i(rst),
        .inst_valid_i,
        .inst_i,
        .pc_i,
        .stall_o,
        .dmem_en_o,
        .dmem_we_o,
        .dmem_addr_o,
        .dmem_wdata_o,
        .dmem_rdata_i,
        .debug_wb_pc_o,
        .debug_wb_rf_we_o,
        .debug_wb_rf_wnum_o,
        .debug_wb_rf_wdata_o
    );

    task automatic check_eq(input string what, input logic [31:0] expv, input logic [31:0] actv);
        checks++;
        if (expv !== actv) begin
            errors++;
            $display("error: %s %s expected %h actual %h", test_name, what, expv, actv);
        end
    endtask

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [4:0] rand_reg(input logic allow_zero);
        logic [31:0] r;
        logic [4:0] sel;
        r = rand_bits(3);
        sel = {2'b00, r[2:0]};
        if (!allow_zero && sel == 5'd0) begin
            sel = 5'd7;
        end
        return sel;
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {a, ~a, a ^ 8'h5a, {a[3:0], a[7:4]}};
    endfunction

    // random add.w/sub.w/and/or/xor/addi.w/lu12i.w over r0..r7
    function automatic logic [31:0] gen_alu(input logic allow_r0);
        logic [31:0] kind;
        logic [31:0] r;
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        logic [31:0] w;
        kind = rand_bits(3);
        rd = rand_reg(allow_r0);
        rj = rand_reg(1'b1);
        rk = rand_reg(1'b1);
        case (kind[2:0])
            3'd0: w = 32'h0010_0000 | {17'b0, rk, rj, rd};
            3'd1: w = 32'h0011_0000 | {17'b0, rk, rj, rd};
            3'd2: w = 32'h0014_8000 | {17'b0, rk, rj, rd};
            3'd3: w = 32'h0015_0000 | {17'b0, rk, rj, rd};
            3'd4: w = 32'h0015_8000 | {17'b0, rk, rj, rd};
            3'd5, 3'd6: begin
                r = rand_bits(12);
                w = 32'h0280_0000 | {10'b0, r[11:0], rj, rd};
            end
            default: begin
                r = rand_bits(20);
                w = 32'h1400_0000 | {7'b0, r[19:0], rd};
            end
        endcase
        return w;
    endfunction

    // architectural model called once per accepted instruction
    function automatic void ref_exec(input logic [31:0] w, input logic [31:0] pc_val);
        logic [4:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] res;
        logic wr;
        rd = w[4:0];
        a = sregs[w[9:5]];
        b = sregs[w[14:10]];
        imm = {{20{w[21]}}, w[21:10]};
        addr = a + imm;
        res = '0;
        wr = 1'b1;
        case (w & 32'hffff_8000)
            32'h0010_0000: res = a + b;
            32'h0011_0000: res = a - b;
            32'h0014_8000: res = a & b;
            32'h0015_0000: res = a | b;
            32'h0015_8000: res = a ^ b;
            default: begin
                case (w & 32'hffc0_0000)
                    32'h0280_0000: res = a + imm;
                    32'h2880_0000: res = smem[addr[9:2]];
                    32'h2980_0000: begin
                        smem[addr[9:2]] = sregs[rd];
                        exp_saddr.push_back(addr);
                        exp_sdata.push_back(sregs[rd]);
                        wr = 1'b0;
                    end
                    default: begin
                        if ((w & 32'hfe00_0000) == 32'h1400_0000) begin
                            res = {w[24:5], 12'h000};
                        end else begin
                            // unknown word is a bubble
                            wr = 1'b0;
                        end
                    end
                endcase
            end
        endcase
        if (wr && rd != 5'd0) begin
            sregs[rd] = res;
            exp_wnum.push_back({27'b0, rd});
            exp_wdata.push_back(res);
            exp_pc.push_back(pc_val);
        end
    endfunction

    // present one slot and retry while the backend stalls
    task automatic issue(input logic valid, input logic [31:0] word);
        logic taken;
        inst_valid_i = valid;
        inst_i = word;
        pc_i = pc_next;
        taken = 1'b0;
        while (!taken) begin
            taken = !stall_o || !valid;
            if (!taken) begin
                stall_cycles++;
            end
            @(negedge clk);
        end
        if (valid) begin
            ref_exec(word, pc_next);
            pc_next = pc_next + 32'd4;
        end
        inst_valid_i = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        int test_errors;
        while (exp_wnum.size() != 0 || exp_saddr.size() != 0) begin
            @(negedge clk);
        end
        // stray writebacks would show up here
        repeat (4) @(negedge clk);
        test_errors = errors - err_mark;
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    // memory model returns read data one cycle after the request
    always @(negedge clk) begin
        dmem_rdata_i = read_hold;
        if (!rst && dmem_en_o) begin
            if (dmem_we_o) begin
                if (exp_saddr.size() == 0) begin
                    errors++;
                    $display("store to %h in test %s was not expected", dmem_addr_o, test_name);
                end else begin
                    check_eq("store address", exp_saddr.pop_front(), dmem_addr_o);
                    check_eq("store data", exp_sdata.pop_front(), dmem_wdata_o);
                end
                dmem[dmem_addr_o[9:2]] = dmem_wdata_o;
            end else begin
                read_hold = dmem[dmem_addr_o[9:2]];
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && debug_wb_rf_we_o) begin
            if (exp_wnum.size() == 0) begin
                errors++;
                $display("writeback to r%0d in test %s was not expected",
                         debug_wb_rf_wnum_o, test_name);
            end else begin
                check_eq("wb register", exp_wnum.pop_front(), {27'b0, debug_wb_rf_wnum_o});
                check_eq("wb data", exp_wdata.pop_front(), debug_wb_rf_wdata_o);
                check_eq("wb pc", exp_pc.pop_front(), debug_wb_pc_o);
            end
        end
    end

    initial begin
        repeat (slot_total * 4 + 100) @(posedge clk);
        $display("watchdog expired in test %s with %0d writebacks still outstanding",
                 test_name, exp_wnum.size());
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [4:0] rx;
        logic [4:0] ry;
        logic [4:0] rz;
        logic [4:0] rb;
        int mark;
        for (int i = 0; i < 256; i++) begin
            smem[i] = fill_word(i[7:0]);
            dmem[i] = fill_word(i[7:0]);
        end
        for (int i = 0; i < 32; i++) begin
            sregs[i] = '0;
        end
        do begin
            @(negedge clk);
        end while (rst);

        start_test("reset idle");
        // a real load word that must be ignored while inst_valid_i is low
        inst_i = 32'h2880_0001;
        repeat (idle_cycles) begin
            check_eq("stall_o", 32'd0, {31'b0, stall_o});
            check_eq("dmem_en_o", 32'd0, {31'b0, dmem_en_o});
            check_eq("debug_wb_rf_we_o", 32'd0, {31'b0, debug_wb_rf_we_o});
            @(negedge clk);
        end
        end_test();

        start_test("alu chains");
        repeat (alu_count) issue(1'b1, gen_alu(1'b0));
        end_test();

        start_test("store load");
        for (int i = 1; i < 8; i++) begin
            r = rand_bits(12);
            issue(1'b1, 32'h0280_0000 | {10'b0, r[11:0], 5'd0, i[4:0]});
        end
        repeat (mem_pairs) begin
            rb = rand_reg(1'b1);
            rz = rand_reg(1'b1);
            rx = rand_reg(1'b0);
            r = rand_bits(12);
            issue(1'b1, 32'h2980_0000 | {10'b0, r[11:0], rb, rz});
            issue(1'b1, 32'h2880_0000 | {10'b0, r[11:0], rb, rx});
        end
        end_test();

        start_test("load use");
        for (int i = 0; i < use_pairs; i++) begin
            rx = rand_reg(1'b0);
            ry = rand_reg(1'b0);
            rz = rand_reg(1'b1);
            r = rand_bits(8);
            mark = stall_cycles;
            issue(1'b1, 32'h2880_0000 | {10'b0, 2'b00, r[7:0], 2'b00, 5'd0, rx});
            if (i % 2 == 0) begin
                issue(1'b1, 32'h0010_0000 | {17'b0, rz, rx, ry});
            end else begin
                issue(1'b1, 32'h0011_0000 | {17'b0, rx, rz, ry});
            end
            // the bubble slot absorbs the single stall cycle
            issue(1'b1, nop_word);
            check_eq("stall cycles", 32'd1, stall_cycles - mark);
        end
        end_test();

        start_test("gaps and r0");
        repeat (gap_count) begin
            r = rand_bits(2);
            if (r[1:0] == 2'd0) begin
                issue(1'b0, rand_bits(32));
            end else begin
                issue(1'b1, gen_alu(1'b1));
            end
        end
        end_test();

        start_test("unknown words");
        repeat (junk_count) begin
            r = rand_bits(2);
            case (r[1:0])
                2'd0: issue(1'b1, rand_bits(32));
                2'd1: issue(1'b1, nop_word);
                default: issue(1'b1, gen_alu(1'b0));
            endcase
        end
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end
endmodule

`default_nettype wire
